/* hw/cheat_pkg.sv */
// cheat engine program ROM, shared types and constants
// download bytes, processor instruction words and the
// nine byte to four word packing geometry
`default_nettype none

package cheat_pkg;

    // widths of the two payloads
    localparam int byte_w = 8;                  // download port byte
    localparam int word_w = 18;                 // soft processor opcode width

    // one byte from the loader
    typedef logic [byte_w-1:0] cheat_byte_t;

    // one instruction word as stored in the program RAM
    typedef logic [word_w-1:0] cheat_word_t;

    // packing group, 9 bytes = 72 bits = 4 words
    localparam int group_bytes = 9;
    localparam int group_words = 4;

    // default descramble key
    // low byte seeds the per-address swap mask
    // high byte is xored into the data between the two swap passes
    localparam logic [15:0] default_scramble_key = 16'h5a3c;

endpackage

`default_nettype wire

/* hw/cheat_descrambler.sv */
// cheat ROM download descrambler
// undoes the per-address bit pair shuffle and key xor of each
// download byte, pure combinational; passes data through when off
`timescale 1ns/10ps
`default_nettype none

module cheat_descrambler
    import cheat_pkg::*;
#(
    parameter bit          scramble_en  = 1'b0,                 // 1 = bytes arrive scrambled
    parameter logic [15:0] scramble_key = default_scramble_key  // {xor value, mask seed}
) (
    input  cheat_byte_t prog_addr,      // low byte of download address
    input  cheat_byte_t prog_data,      // byte as sent by the loader
    output cheat_byte_t plain_byte      // byte ready for the packer
);

    // swap the two bits of each pair whose select bit is set
    // sel[0] -> bits 1:0, sel[1] -> bits 3:2 and so on
    function automatic cheat_byte_t swap_pairs(input cheat_byte_t din, input logic [3:0] sel);
        cheat_byte_t dout;
        dout = din;
        for (int p = 0; p < 4; p++) begin
            if (sel[p]) begin
                dout[2*p]   = din[2*p+1];
                dout[2*p+1] = din[2*p];
            end
        end
        return dout;
    endfunction

    cheat_byte_t mask;      // address dependent swap selects
    cheat_byte_t stage1;    // after first swap pass
    cheat_byte_t stage2;    // after key xor
    cheat_byte_t stage3;    // after second swap pass

    always_comb begin
        mask   = prog_addr ^ scramble_key[7:0];
        stage1 = swap_pairs(prog_data, mask[3:0]);  // low mask nibble first
        stage2 = stage1 ^ scramble_key[15:8];
        stage3 = swap_pairs(stage2, mask[7:4]);     // then the high nibble
    end

    // bypass for unscrambled downloads
    always_comb begin
        if (scramble_en) begin
            plain_byte = stage3;
        end else begin
            plain_byte = prog_data;
        end
    end

endmodule

`default_nettype wire

/* hw/cheat_word_packer.sv */
// cheat ROM word packer
// gathers nine download bytes into four 18-bit instruction words
// and writes them at consecutive RAM addresses; a rising edge of
// prog_en restarts the group and the write address
`timescale 1ns/10ps
`default_nettype none

module cheat_word_packer
    import cheat_pkg::*;
#(
    parameter int aw = 10               // RAM address width
) (
    input  logic          clk_rom,
    input  logic          rst,          // async, active high
    input  logic          prog_en,      // download window
    input  logic          prog_wr,      // byte strobe
    input  cheat_byte_t   plain_byte,   // descrambled byte
    output cheat_word_t   word_data,    // packed word for the RAM
    output logic [aw-1:0] word_addr,    // RAM write address
    output logic          word_we       // one cycle per word
);

    localparam int cnt_w = $clog2(group_bytes);     // counts 0..8
    localparam int idx_w = $clog2(group_words);     // word slot in group
    localparam int sr_w  = 2 * $bits(cheat_byte_t); // two bytes of history
    localparam int win_w = sr_w + $bits(cheat_byte_t);

    logic             last_en;      // prog_en one cycle late
    logic             restart;      // new download seen
    logic             accept;       // byte taken this cycle
    logic             word_end;     // this byte completes a word
    logic [cnt_w-1:0] byte_cnt;     // position within group
    logic [idx_w-1:0] word_idx;     // which of the four words
    logic [sr_w-1:0]  byte_sr;      // last two bytes, oldest in low byte
    logic [win_w-1:0] window;       // new byte on top of history
    logic [win_w-1:0] aligned;      // window moved to word boundary

    // edge of the download window, one cycle late
    assign restart = prog_en & ~last_en;

    // strobes outside the window are ignored, restart cycle drops its byte
    assign accept = prog_en & prog_wr & ~restart;

    // even nonzero counts close a word: 2, 4, 6, 8
    assign word_end = (byte_cnt != '0) && !byte_cnt[0];

    // count 2 -> word 0, count 8 -> word 3
    assign word_idx = idx_w'((byte_cnt >> 1) - 1'b1);

    // word k starts 2k bits into the 24-bit window
    assign window  = {plain_byte, byte_sr};
    assign aligned = window >> {word_idx, 1'b0};

    // control state
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            last_en   <= 1'b0;
            byte_cnt  <= '0;
            word_addr <= '0;
            word_we   <= 1'b0;
        end else begin
            last_en <= prog_en;
            if (restart) begin
                byte_cnt  <= '0;        // new group
                word_addr <= '0;        // back to the start of the RAM
                word_we   <= 1'b0;      // nothing pending after a restart
            end else begin
                word_we <= accept & word_end;
                if (accept) begin
                    if (byte_cnt == cnt_w'(group_bytes - 1)) begin
                        byte_cnt <= '0;     // group done
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                // step past the word being written now
                if (word_we) begin
                    word_addr <= word_addr + 1'b1;  // wraps at the top
                end
            end
        end
    end

    // payload path
    always_ff @(posedge clk_rom) begin
        if (restart) begin
            byte_sr <= '0;              // drop partial data
        end else if (accept) begin
            byte_sr <= {plain_byte, byte_sr[sr_w-1:$bits(cheat_byte_t)]};
            if (word_end) begin
                word_data <= aligned[$bits(cheat_word_t)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cheat_dual_ram.sv */
// cheat ROM program memory
// dual clock RAM, write port from the download side and a
// registered read port for the soft processor fetch
`timescale 1ns/10ps
`default_nettype none

module cheat_dual_ram
    import cheat_pkg::*;
#(
    parameter int aw = 10               // 2**aw words
) (
    // write side
    input  logic          clk_rom,
    input  logic          word_we,
    input  logic [aw-1:0] word_addr,
    input  cheat_word_t   word_data,
    // fetch side
    input  logic          clk_pico,
    input  logic [aw-1:0] iaddr,
    output cheat_word_t   raw_word      // one clk_pico cycle after iaddr
);

    localparam int depth = 2 ** aw;

    // contents are undefined until loaded
    cheat_word_t mem [depth];

    // download writes
    always_ff @(posedge clk_rom) begin
        if (word_we) begin
            mem[word_addr] <= word_data;
        end
    end

    // instruction fetch, registered output
    always_ff @(posedge clk_pico) begin
        raw_word <= mem[iaddr];
    end

endmodule

`default_nettype wire

/* hw/cheat_rom.sv */
// cheat engine program ROM, top level
// download bytes are descrambled, packed nine to four into
// 18-bit words and stored in a dual clock RAM; fetch data reads
// zero until the first word has been written since reset
`timescale 1ns/10ps
`default_nettype none

module cheat_rom
    import cheat_pkg::*;
#(
    parameter int          aw           = 10,                   // fetch address width
    parameter bit          scramble_en  = 1'b0,                 // scrambled downloads
    parameter logic [15:0] scramble_key = default_scramble_key
) (
    input  logic          rst,          // async, active high
    input  logic          clk_rom,      // download clock
    input  logic          clk_pico,     // processor clock
    // fetch port
    input  logic [aw-1:0] iaddr,
    output cheat_word_t   idata,
    // download port
    input  logic          prog_en,      // rising edge restarts loading
    input  logic          prog_wr,      // byte strobe
    input  cheat_byte_t   prog_addr,
    input  cheat_byte_t   prog_data
);

    cheat_byte_t   plain_byte;      // descrambled download byte
    cheat_word_t   word_data;       // packed word
    logic [aw-1:0] word_addr;
    logic          word_we;
    cheat_word_t   raw_word;        // RAM read data
    logic          loaded;          // some word written since reset

    cheat_descrambler #(
        .scramble_en  (scramble_en),
        .scramble_key (scramble_key)
    ) u_descrambler (
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .plain_byte (plain_byte)
    );

    cheat_word_packer #(
        .aw (aw)
    ) u_packer (
        .clk_rom    (clk_rom),
        .rst        (rst),
        .prog_en    (prog_en),
        .prog_wr    (prog_wr),
        .plain_byte (plain_byte),
        .word_data  (word_data),
        .word_addr  (word_addr),
        .word_we    (word_we)
    );

    cheat_dual_ram #(
        .aw (aw)
    ) u_ram (
        .clk_rom   (clk_rom),
        .word_we   (word_we),
        .word_addr (word_addr),
        .word_data (word_data),
        .clk_pico  (clk_pico),
        .iaddr     (iaddr),
        .raw_word  (raw_word)
    );

    // sticky until reset, a new download keeps it set
    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (word_we) begin
            loaded <= 1'b1;
        end
    end

    // unloaded RAM holds garbage, so fetch sees zero instead
    assign idata = loaded ? raw_word : '0;

endmodule

`default_nettype wire

/* sim/cheat_ref_model.svh */
// cheat ROM reference model for the testbench
// undoes the download scrambling and packs the plain bytes of one
// download nine to four into the expected fetch words
`ifndef cheat_ref_model_svh
`define cheat_ref_model_svh

// plain byte the ROM should see for one download byte
function automatic cheat_byte_t unscramble_model(input cheat_byte_t addr,
                                                 input cheat_byte_t data);
    cheat_byte_t mask;
    cheat_byte_t b;
    mask = addr ^ scramble_key[7:0];        // per-address swap selects
    b    = data;
    // first pass, low mask nibble picks the pairs
    for (int p = 0; p < 4; p++) begin
        if (mask[p]) begin
            b[2*p +: 2] = {b[2*p], b[2*p+1]};
        end
    end
    b = b ^ scramble_key[15:8];             // key xor sits between the passes
    // second pass under the high nibble
    for (int p = 0; p < 4; p++) begin
        if (mask[p+4]) begin
            b[2*p +: 2] = {b[2*p], b[2*p+1]};
        end
    end
    if (scramble_en) begin
        return b;
    end
    return data;                            // plain download
endfunction

// lays the bytes of each group end to end and writes the finished
// words into exp_mem from address 0; returns the number of words
function automatic int pack_model(input cheat_byte_t q[$]);
    logic [byte_w*group_bytes-1:0] stream;  // one group, first byte lowest
    logic [aw-1:0]                 waddr;
    int                            nwords;
    int                            nb;
    waddr  = '0;
    nwords = 0;
    for (int g = 0; g * group_bytes < q.size(); g++) begin
        nb = q.size() - g * group_bytes;    // bytes in this group
        if (nb > group_bytes) begin
            nb = group_bytes;
        end
        stream = '0;
        for (int i = 0; i < nb; i++) begin
            stream[byte_w*i +: byte_w] = q[g*group_bytes+i];
        end
        // word k only exists once byte 2k+2 of the group has arrived
        for (int k = 0; k < group_words; k++) begin
            if (2*k + 2 < nb) begin
                exp_mem[waddr] = stream[word_w*k +: word_w];
                waddr  = waddr + 1'b1;      // wraps like the RAM
                nwords++;
            end
        end
    end
    return nwords;
endfunction

`endif

/* sim/cheat_rom_tb.sv */
// cheat engine program ROM testbench
// streams random downloads into the ROM, reads every word back
// through the fetch port and checks it against the reference model
`timescale 1ns/10ps
`default_nettype none

module cheat_rom_tb
    import cheat_pkg::*;
#(
    parameter int          aw           = 10,
    parameter bit          scramble_en  = 1'b0,     // overridden by the build
    parameter logic [15:0] scramble_key = default_scramble_key
);

    localparam int depth      = 2 ** aw;
    localparam int full_bytes = 18 * group_bytes;   // 162 bytes
    localparam int full_words = 18 * group_words;   // 72 words
    localparam int wait_limit = 64;                 // clk_pico cycles per wait

    logic          rst;
    logic          clk_rom  = 1'b0;
    logic          clk_pico = 1'b0;
    logic [aw-1:0] iaddr;
    cheat_word_t   idata;
    logic          prog_en;
    logic          prog_wr;
    cheat_byte_t   prog_addr;
    cheat_byte_t   prog_data;

    int          seed;
    int          checks;
    int          errors;
    int          timeouts;
    cheat_byte_t plain_q[$];        // plain bytes of the current download
    cheat_word_t exp_mem[depth];    // what the RAM should hold

    `include "cheat_ref_model.svh"

    cheat_rom #(
        .aw           (aw),
        .scramble_en  (scramble_en),
        .scramble_key (scramble_key)
    ) dut_i (
        .rst       (rst),
        .clk_rom   (clk_rom),
        .clk_pico  (clk_pico),
        .iaddr     (iaddr),
        .idata     (idata),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_addr (prog_addr),
        .prog_data (prog_data)
    );

    always #2 clk_rom = ~clk_rom;   // 4 ns

    // same period, 1 ns behind
    always begin
        #1;
        forever #2 clk_pico = ~clk_pico;
    end

    task automatic rom_tick();
        @(posedge clk_rom);
        #1;
    endtask

    task automatic pico_tick();
        @(posedge clk_pico);
        #1;
    endtask

    // one fetch, data is registered on the next clk_pico edge
    task automatic fetch_check(input logic [aw-1:0] addr, input cheat_word_t exp);
        pico_tick();
        iaddr = addr;
        pico_tick();
        checks++;
        assert (idata === exp) else begin
            $display("** Error: idata at iaddr 0x%0h expected 0x%05h got 0x%05h",
                     addr, exp, idata);
            errors++;
        end
    endtask

    task automatic check_range(input int count);
        for (int a = 0; a < count; a++) begin
            fetch_check(aw'(a), exp_mem[aw'(a)]);
        end
    endtask

    // poll the fetch port until the last word of a download shows up
    task automatic wait_for_word(input logic [aw-1:0] addr);
        int n;
        bit hit;
        hit = 1'b0;
        for (n = 0; n < wait_limit && !hit; n++) begin
            pico_tick();
            iaddr = addr;
            pico_tick();
            hit = (idata === exp_mem[addr]);
        end
        if (!hit) begin
            $display("timeout: the word at address 0x%0h never reached the fetch port", addr);
            timeouts++;
        end
    endtask

    // rising prog_en, with a junk strobe on the restart cycle
    task automatic open_window();
        prog_en = 1'b0;
        prog_wr = 1'b0;
        rom_tick();                         // packer sees prog_en low
        prog_en   = 1'b1;
        prog_wr   = 1'b1;
        prog_addr = '0;
        prog_data = cheat_byte_t'($random(seed));
        rom_tick();                         // restart edge, byte dropped
        prog_wr = 1'b0;
    endtask

    task automatic close_window();
        prog_en = 1'b0;
        prog_wr = 1'b0;
        // word_we one cycle after the byte, RAM write the cycle after
        for (int n = 0; n < 3; n++) begin
            rom_tick();
        end
    endtask

    task automatic run_download(input int nbytes, input bit gaps);
        int          nwords;
        cheat_byte_t raw;
        plain_q.delete();
        open_window();
        for (int i = 0; i < nbytes; i++) begin
            if (gaps && (($random(seed) & 3) == 0)) begin
                rom_tick();                 // idle cycle inside the window
            end
            raw       = cheat_byte_t'($random(seed));
            prog_addr = cheat_byte_t'(i);   // index mod 256
            prog_data = raw;
            prog_wr   = 1'b1;
            rom_tick();
            prog_wr   = 1'b0;
            plain_q.push_back(unscramble_model(cheat_byte_t'(i), raw));
        end
        close_window();
        nwords = pack_model(plain_q);
        $display("download of %0d bytes, %0d words", nbytes, nwords);
        if (nwords > 0) begin
            wait_for_word(aw'(nwords - 1));
        end
    endtask

    // prog_wr pulses with the window closed
    task automatic stray_strobes(input int count);
        prog_en = 1'b0;
        for (int i = 0; i < count; i++) begin
            prog_addr = cheat_byte_t'($random(seed));
            prog_data = cheat_byte_t'($random(seed));
            prog_wr   = 1'b1;
            rom_tick();
            prog_wr   = 1'b0;
            rom_tick();
        end
    endtask

    initial begin
        seed      = 32'h37649add;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        exp_mem   = '{default: '0};
        rst       = 1'b1;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        iaddr     = '0;

        repeat (16) @(posedge clk_rom);
        #1;
        rst = 1'b0;

        // nothing loaded yet, fetch reads zero
        fetch_check('0, '0);
        fetch_check(aw'(1), '0);
        fetch_check(aw'(full_words - 1), '0);
        fetch_check('1, '0);

        run_download(full_bytes, 1'b1);     // random gaps between bytes
        check_range(full_words);

        // reset with a loaded RAM, fetch goes back to zero
        rst = 1'b1;
        repeat (2) rom_tick();
        rst = 1'b0;
        fetch_check('0, '0);
        fetch_check(aw'(full_words - 1), '0);

        // partial group, then a shorter reload over the first words
        run_download(5, 1'b0);
        run_download(13, 1'b1);
        check_range(full_words);

        // window closed with the packer mid group at address 5
        stray_strobes(8);
        check_range(full_words);

        // three bytes make one word, the rest of the RAM keeps its data
        run_download(3, 1'b0);
        check_range(full_words);

        $display("scramble_en %0d: %0d checks, %0d errors, %0d timeouts",
                 scramble_en, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+sim
hw/cheat_pkg.sv
hw/cheat_descrambler.sv
hw/cheat_word_packer.sv
hw/cheat_dual_ram.sv
hw/cheat_rom.sv
sim/cheat_rom_tb.sv

/* Makefile */
# Verilator flow for the cheat engine program ROM
# test builds and runs the testbench without and with scrambling

TOP := cheat_rom_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   run the testbench with scramble_en=0 and scramble_en=1"
	@echo "  clean  remove the build directories"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module $(TOP) -Gscramble_en=0 --Mdir obj_plain
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module $(TOP) -Gscramble_en=1 --Mdir obj_scrambled
	out=$$(./obj_plain/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"
	out=$$(./obj_scrambled/V$(TOP)); \
		echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_plain obj_scrambled
